/* src.f */
src/fetch_pkg.sv
src/predecode.sv
src/btb.sv
src/branch_pred.sv
src/fetch_pc.sv
src/fetch_frontend.sv
bench/fetch_frontend_sva.sv
bench/fetch_frontend_tb.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - src/fetch_pkg.sv
  - src/predecode.sv
  - src/btb.sv
  - src/branch_pred.sv
  - src/fetch_pc.sv
  - src/fetch_frontend.sv
  - target: test
    files:
      - bench/fetch_frontend_sva.sv
      - bench/fetch_frontend_tb.sv

/* bench/fetch_frontend_tb.sv */
// Testbench for the fetch front end
// Clock and reset, instruction memory model, predictor model, directed tests

`timescale 1ns/1ps

module fetch_frontend_tb;

  localparam int                     FETCH_WIDTH = 2;
  localparam int                     BTB_WAYS    = 2;
  localparam fetch_pkg::addr_t       RESET_PC    = 32'h0000_0100;
  localparam fetch_pkg::instr_t      ALU_WORD    = 32'h0000_0013;
  localparam fetch_pkg::instr_t      BR_WORD     = 32'h0000_0063;
  localparam logic [FETCH_WIDTH-1:0] ALL_SLOTS   = '1;
  localparam int                     TIMEOUT     = 16;

  logic                                clock;
  logic                                reset;
  fetch_pkg::addr_t                    fetch_addr;
  fetch_pkg::instr_t [FETCH_WIDTH-1:0] fetch_instr;
  logic [FETCH_WIDTH-1:0]              fetch_instr_valid;
  logic                                stall;
  logic                                retire_valid;
  fetch_pkg::addr_t                    retire_pc;
  fetch_pkg::addr_t                    retire_target;
  logic                                retire_taken;
  logic                                retire_pred_taken;
  logic                                retire_is_branch;
  logic [FETCH_WIDTH-1:0]              out_valid;
  fetch_pkg::addr_t                    out_pc;
  logic [FETCH_WIDTH-1:0]              out_pred_taken;
  fetch_pkg::addr_t                    out_target;
  logic                                mispredict;

  fetch_pkg::instr_t imem [fetch_pkg::addr_t];
  int                mem_gen;
  // Local history and 2-bit counters, 16 entries each
  logic [3:0]        hist_model [16];
  fetch_pkg::ctr_t   pht_model [16];
  int                checks;
  int                errors;

  fetch_frontend #(
    .FETCH_WIDTH (FETCH_WIDTH),
    .RESET_PC    (RESET_PC)
  ) fetch_frontend_i (
    .clock             (clock),
    .reset             (reset),
    .fetch_addr        (fetch_addr),
    .fetch_instr       (fetch_instr),
    .fetch_instr_valid (fetch_instr_valid),
    .stall             (stall),
    .retire_valid      (retire_valid),
    .retire_pc         (retire_pc),
    .retire_target     (retire_target),
    .retire_taken      (retire_taken),
    .retire_pred_taken (retire_pred_taken),
    .retire_is_branch  (retire_is_branch),
    .out_valid         (out_valid),
    .out_pc            (out_pc),
    .out_pred_taken    (out_pred_taken),
    .out_target        (out_target),
    .mispredict        (mispredict)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Unwritten addresses read as an ALU instruction
  function automatic fetch_pkg::instr_t read_word(input fetch_pkg::addr_t a);
    if ($isunknown(a) || !imem.exists(a)) begin
      return ALU_WORD;
    end
    return imem[a];
  endfunction

  // Memory answers the fetch address in the same cycle
  always @(fetch_addr or mem_gen) begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      fetch_instr[i] = read_word(fetch_addr + fetch_pkg::addr_t'(4 * i));
    end
  end

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("%s finished with %0d errors", name, errors - start_errors);
  endtask

  task automatic write_instr(input fetch_pkg::addr_t a, input fetch_pkg::instr_t w);
    imem[a] = w;
    mem_gen++;
  endtask

  // Shift the outcome into the history, then move the counter it selects
  function automatic void model_update(input fetch_pkg::addr_t pc, input logic taken);
    logic [3:0] idx;
    logic [3:0] h;
    idx = pc[5:2];
    h = {hist_model[idx][2:0], taken};
    hist_model[idx] = h;
    if (taken && pht_model[h] != 2'b11) begin
      pht_model[h] = pht_model[h] + 2'd1;
    end else if (!taken && pht_model[h] != 2'b00) begin
      pht_model[h] = pht_model[h] - 2'd1;
    end
  endfunction

  function automatic logic model_taken(input fetch_pkg::addr_t pc);
    return pht_model[hist_model[pc[5:2]]][1];
  endfunction

  // One retired branch for one cycle, mispredict checked mid-cycle
  task automatic retire_branch(input fetch_pkg::addr_t pc, input fetch_pkg::addr_t target,
                               input logic taken, input logic pred);
    retire_valid      = 1'b1;
    retire_is_branch  = 1'b1;
    retire_pc         = pc;
    retire_target     = target;
    retire_taken      = taken;
    retire_pred_taken = pred;
    model_update(pc, taken);
    @(negedge clock);
    compare("mispredict", mispredict, taken != pred);
    step();
    retire_valid     = 1'b0;
    retire_is_branch = 1'b0;
  endtask

  // A wrongly predicted not-taken branch just before a redirects fetch there
  task automatic steer_to(input fetch_pkg::addr_t a);
    int waited;
    retire_branch(a - 32'd4, a, 1'b0, 1'b1);
    waited = 0;
    while (fetch_addr !== a && waited < TIMEOUT) begin
      step();
      waited++;
    end
    if (fetch_addr !== a) begin
      errors++;
      $display("Fetch address did not reach %h within %0d cycles", a, TIMEOUT);
    end
  endtask

  task automatic sequential_fetch();
    int               start_errors;
    fetch_pkg::addr_t expect_pc;
    start_errors = errors;
    expect_pc = RESET_PC;
    compare("fetch_addr", fetch_addr, RESET_PC);
    compare("out_valid", out_valid, 0);
    for (int i = 0; i < 4; i++) begin
      step();
      compare("out_pc", out_pc, expect_pc);
      compare("out_valid", out_valid, ALL_SLOTS);
      compare("out_pred_taken", out_pred_taken, 0);
      expect_pc = expect_pc + 32'd8;
    end
    report_test("sequential fetch", start_errors);
  endtask

  task automatic stall_hold();
    int               start_errors;
    fetch_pkg::addr_t held;
    start_errors = errors;
    // Four groups of two words fetched since reset
    held = RESET_PC + 32'h20;
    stall = 1'b1;
    for (int i = 0; i < 3; i++) begin
      step();
      compare("fetch_addr", fetch_addr, held);
      compare("out_valid", out_valid, 0);
    end
    stall = 1'b0;
    step();
    compare("out_pc", out_pc, held);
    compare("out_valid", out_valid, ALL_SLOTS);
    compare("fetch_addr", fetch_addr, held + 32'd8);
    report_test("stall", start_errors);
  endtask

  task automatic train_branch();
    int               start_errors;
    fetch_pkg::addr_t br;
    fetch_pkg::addr_t tgt;
    logic             taken;
    start_errors = errors;
    br = 32'h0000_0800 + fetch_pkg::addr_t'(($urandom % 3) * 8);
    tgt = br + 32'h400;
    write_instr(br, BR_WORD);
    repeat (4) retire_branch(br, tgt, 1'b1, 1'b1);
    steer_to(br);
    taken = model_taken(br);
    step();
    compare("out_pc", out_pc, br);
    compare("out_pred_taken", out_pred_taken, taken ? 2'b01 : 2'b00);
    compare("out_valid", out_valid, taken ? 2'b01 : ALL_SLOTS);
    compare("out_target", out_target, taken ? tgt : br + 32'd8);
    step();
    compare("out_pc", out_pc, taken ? tgt : br + 32'd8);
    report_test("training", start_errors);
  endtask

  task automatic mispredict_redirect();
    int start_errors;
    start_errors = errors;
    // Predicted not taken, actually taken
    retire_branch(32'h0000_3004, 32'h0000_4000, 1'b1, 1'b0);
    compare("fetch_addr", fetch_addr, 32'h0000_4000);
    compare("out_valid", out_valid, 0);
    // Predicted taken, actually not taken
    retire_branch(32'h0000_300C, 32'h0000_4800, 1'b0, 1'b1);
    compare("fetch_addr", fetch_addr, 32'h0000_3010);
    compare("out_valid", out_valid, 0);
    step();
    compare("out_pc", out_pc, 32'h0000_3010);
    compare("out_valid", out_valid, ALL_SLOTS);
    report_test("mispredict redirect", start_errors);
  endtask

  task automatic btb_replacement();
    int                     start_errors;
    fetch_pkg::addr_t       br [3];
    fetch_pkg::addr_t       tgt [3];
    logic                   hit;
    logic [FETCH_WIDTH-1:0] mask;
    start_errors = errors;
    // Same set and history entry, tags 1, 2 and 3
    br[0] = 32'h0100_0018;
    br[1] = 32'h0200_0018;
    br[2] = 32'h0300_0018;
    for (int i = 0; i < 3; i++) begin
      tgt[i] = 32'h0000_5000 + fetch_pkg::addr_t'(i * 32'h100);
      write_instr(br[i], BR_WORD);
      repeat (4) retire_branch(br[i], tgt[i], 1'b1, 1'b1);
    end
    for (int i = 0; i < 3; i++) begin
      // Only the most recent ways survive
      hit = (i >= 3 - BTB_WAYS);
      steer_to(br[i]);
      mask = (hit && model_taken(br[i])) ? 2'b01 : 2'b00;
      step();
      compare("out_pc", out_pc, br[i]);
      compare("out_pred_taken", out_pred_taken, mask);
      compare("fetch_addr", fetch_addr, mask[0] ? tgt[i] : br[i] + 32'd8);
    end
    report_test("target buffer replacement", start_errors);
  endtask

  initial begin
    reset             = 1'b1;
    stall             = 1'b0;
    fetch_instr_valid = ALL_SLOTS;
    retire_valid      = 1'b0;
    retire_pc         = '0;
    retire_target     = '0;
    retire_taken      = 1'b0;
    retire_pred_taken = 1'b0;
    retire_is_branch  = 1'b0;
    checks            = 0;
    errors            = 0;
    for (int i = 0; i < 16; i++) begin
      hist_model[i] = '0;
      pht_model[i]  = fetch_pkg::CTR_WEAK_NT;
    end
    mem_gen = 1;
    void'($urandom(57199));
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    sequential_fetch();
    stall_hold();
    train_branch();
    mispredict_redirect();
    btb_replacement();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* bench/fetch_frontend_sva.sv */
// Assertions on the fetch front end output stage
// Reset clear, one-hot prediction mask, squash after a mispredict

`timescale 1ns/1ps

module fetch_frontend_sva #(
  parameter int FETCH_WIDTH = 2
) (
  input logic                   clock,
  input logic                   reset,
  input logic [FETCH_WIDTH-1:0] out_valid,
  input logic [FETCH_WIDTH-1:0] out_pred_taken,
  input logic                   mispredict
);

  // Output register comes out of reset empty
  reset_clears_valid: assert property (@(posedge clock) reset |=> out_valid == '0)
    else $error("out_valid not zero after reset");

  // At most one slot predicted per group
  mask_onehot: assert property (
    @(posedge clock) disable iff (reset) $onehot0(out_pred_taken))
    else $error("out_pred_taken has more than one bit set");

  squash_after_mispredict: assert property (
    @(posedge clock) disable iff (reset) mispredict |=> out_valid == '0)
    else $error("out_valid not squashed after mispredict");

endmodule

bind fetch_frontend fetch_frontend_sva #(
  .FETCH_WIDTH (FETCH_WIDTH)
) fetch_frontend_sva_i (
  .clock          (clock),
  .reset          (reset),
  .out_valid      (out_valid),
  .out_pred_taken (out_pred_taken),
  .mispredict     (mispredict)
);

/* src/fetch_frontend.sv */
// Top level of the fetch front end
// Connects fetch_pc, predecode and branch_pred and sets their parameters

`timescale 1ns/1ps

module fetch_frontend #(
  parameter int               FETCH_WIDTH    = 2,
  parameter int               BHT_INDEX_BITS = 4,
  parameter int               HIST_BITS      = 4,
  parameter int               BTB_SET_BITS   = 3,
  parameter int               BTB_WAYS       = 2,
  parameter int               TAG_BITS       = 8,
  parameter fetch_pkg::addr_t RESET_PC       = 32'h0000_0100
) (
  input  logic                                clock,
  input  logic                                reset,
  output fetch_pkg::addr_t                    fetch_addr,
  input  fetch_pkg::instr_t [FETCH_WIDTH-1:0] fetch_instr,
  input  logic [FETCH_WIDTH-1:0]              fetch_instr_valid,
  input  logic                                stall,
  input  logic                                retire_valid,
  input  fetch_pkg::addr_t                    retire_pc,
  input  fetch_pkg::addr_t                    retire_target,
  input  logic                                retire_taken,
  input  logic                                retire_pred_taken,
  input  logic                                retire_is_branch,
  output logic [FETCH_WIDTH-1:0]              out_valid,
  output fetch_pkg::addr_t                    out_pc,
  output logic [FETCH_WIDTH-1:0]              out_pred_taken,
  output fetch_pkg::addr_t                    out_target,
  output logic                                mispredict
);

  logic [FETCH_WIDTH-1:0] is_branch;
  fetch_pkg::addr_t       next_pc;
  logic [FETCH_WIDTH-1:0] pred_mask;

  predecode #(
    .FETCH_WIDTH (FETCH_WIDTH)
  ) predecode_i (
    .fetch_instr       (fetch_instr),
    .fetch_instr_valid (fetch_instr_valid),
    .is_branch         (is_branch)
  );

  // Prediction stage, mispredict doubles as the fetch redirect
  branch_pred #(
    .FETCH_WIDTH    (FETCH_WIDTH),
    .BHT_INDEX_BITS (BHT_INDEX_BITS),
    .HIST_BITS      (HIST_BITS),
    .BTB_SET_BITS   (BTB_SET_BITS),
    .BTB_WAYS       (BTB_WAYS),
    .TAG_BITS       (TAG_BITS)
  ) branch_pred_i (
    .clock             (clock),
    .reset             (reset),
    .pc                (fetch_addr),
    .is_branch         (is_branch),
    .retire_valid      (retire_valid),
    .retire_pc         (retire_pc),
    .retire_target     (retire_target),
    .retire_taken      (retire_taken),
    .retire_pred_taken (retire_pred_taken),
    .retire_is_branch  (retire_is_branch),
    .next_pc           (next_pc),
    .pred_mask         (pred_mask),
    .redirect          (mispredict)
  );

  fetch_pc #(
    .FETCH_WIDTH (FETCH_WIDTH),
    .RESET_PC    (RESET_PC)
  ) fetch_pc_i (
    .clock             (clock),
    .reset             (reset),
    .stall             (stall),
    .next_pc           (next_pc),
    .pred_mask         (pred_mask),
    .redirect          (mispredict),
    .fetch_instr_valid (fetch_instr_valid),
    .pc                (fetch_addr),
    .out_valid         (out_valid),
    .out_pc            (out_pc),
    .out_pred_taken    (out_pred_taken),
    .out_target        (out_target)
  );

endmodule

/* src/fetch_pc.sv */
// Fetch address register and output stage
// Trims slots after the predicted branch, squashes on stall and redirect

`timescale 1ns/1ps

module fetch_pc #(
  parameter int               FETCH_WIDTH = 2,
  parameter fetch_pkg::addr_t RESET_PC    = 32'h0000_0100
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   stall,
  input  fetch_pkg::addr_t       next_pc,
  input  logic [FETCH_WIDTH-1:0] pred_mask,
  input  logic                   redirect,
  input  logic [FETCH_WIDTH-1:0] fetch_instr_valid,
  output fetch_pkg::addr_t       pc,
  output logic [FETCH_WIDTH-1:0] out_valid,
  output fetch_pkg::addr_t       out_pc,
  output logic [FETCH_WIDTH-1:0] out_pred_taken,
  output fetch_pkg::addr_t       out_target
);

  logic [FETCH_WIDTH-1:0] slot_keep;
  logic                   taken_seen;

  // Slots behind a predicted-taken branch are dropped
  always_comb begin
    taken_seen = 1'b0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      slot_keep[i] = fetch_instr_valid[i] & ~taken_seen;
      taken_seen   = taken_seen | pred_mask[i];
    end
  end

  // A redirect loads pc even while stalled
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (redirect || !stall) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid      <= '0;
      out_pred_taken <= '0;
    end else if (stall || redirect) begin
      out_valid <= '0;
    end else begin
      out_valid      <= slot_keep;
      out_pred_taken <= pred_mask;
    end
  end

  // Group address and predicted successor, held while squashed
  always_ff @(posedge clock) begin
    if (!stall && !redirect) begin
      out_pc     <= pc;
      out_target <= next_pc;
    end
  end

endmodule

/* src/branch_pred.sv */
// Local-history direction predictor with target buffer lookup
// Retire update of history, counters and BTB, mispredict redirect
// Next fetch address selection for the current group

`timescale 1ns/1ps

module branch_pred #(
  parameter int FETCH_WIDTH    = 2,
  parameter int BHT_INDEX_BITS = 4,
  parameter int HIST_BITS      = 4,
  parameter int BTB_SET_BITS   = 3,
  parameter int BTB_WAYS       = 2,
  parameter int TAG_BITS       = 8
) (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::addr_t       pc,
  input  logic [FETCH_WIDTH-1:0] is_branch,
  input  logic                   retire_valid,
  input  fetch_pkg::addr_t       retire_pc,
  input  fetch_pkg::addr_t       retire_target,
  input  logic                   retire_taken,
  input  logic                   retire_pred_taken,
  input  logic                   retire_is_branch,
  output fetch_pkg::addr_t       next_pc,
  output logic [FETCH_WIDTH-1:0] pred_mask,
  output logic                   redirect
);

  localparam int BHT_SIZE = 1 << BHT_INDEX_BITS;
  localparam int PHT_SIZE = 1 << HIST_BITS;

  typedef logic [HIST_BITS-1:0]      hist_t;
  typedef logic [BHT_INDEX_BITS-1:0] bht_idx_t;

  hist_t          hist_q [BHT_SIZE];
  hist_t          hist_d [BHT_SIZE];
  fetch_pkg::ctr_t pht_q [PHT_SIZE];
  fetch_pkg::ctr_t pht_d [PHT_SIZE];

  logic                               retire_br;
  bht_idx_t                           retire_idx;
  hist_t                              retire_hist;
  logic [FETCH_WIDTH-1:0]             btb_hit;
  fetch_pkg::addr_t [FETCH_WIDTH-1:0] btb_target;
  logic [FETCH_WIDTH-1:0]             slot_taken;

  assign retire_br   = retire_valid & retire_is_branch;
  assign retire_idx  = retire_pc[BHT_INDEX_BITS+1:2];
  assign retire_hist = {hist_q[retire_idx][HIST_BITS-2:0], retire_taken};
  assign redirect    = retire_br & (retire_pred_taken != retire_taken);

  // Retire update, seen by this cycle's prediction
  always_comb begin
    hist_d = hist_q;
    pht_d  = pht_q;
    if (retire_br) begin
      hist_d[retire_idx] = retire_hist;
      if (retire_taken && pht_q[retire_hist] != 2'b11) begin
        pht_d[retire_hist] = pht_q[retire_hist] + 2'd1;
      end else if (!retire_taken && pht_q[retire_hist] != 2'b00) begin
        pht_d[retire_hist] = pht_q[retire_hist] - 2'd1;
      end
    end
  end

  btb #(
    .BTB_SET_BITS (BTB_SET_BITS),
    .BTB_WAYS     (BTB_WAYS),
    .TAG_BITS     (TAG_BITS),
    .FETCH_WIDTH  (FETCH_WIDTH)
  ) btb_i (
    .clock         (clock),
    .reset         (reset),
    .lookup_pc     (pc),
    .hit           (btb_hit),
    .hit_target    (btb_target),
    .insert        (retire_br & retire_taken),
    .insert_pc     (retire_pc),
    .insert_target (retire_target)
  );

  for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_slot
    fetch_pkg::addr_t slot_addr;
    bht_idx_t         slot_idx;

    assign slot_addr     = pc + fetch_pkg::addr_t'(4 * i);
    assign slot_idx      = slot_addr[BHT_INDEX_BITS+1:2];
    assign slot_taken[i] = is_branch[i] & pht_d[hist_d[slot_idx]][1] & btb_hit[i];
  end

  // Mispredict overrides, otherwise the lowest predicted slot wins
  always_comb begin
    pred_mask = '0;
    next_pc   = pc + fetch_pkg::addr_t'(4 * FETCH_WIDTH);
    if (redirect) begin
      next_pc = retire_taken ? retire_target : retire_pc + 32'd4;
    end else begin
      for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
        if (slot_taken[i]) begin
          pred_mask    = '0;
          pred_mask[i] = 1'b1;
          next_pc      = btb_target[i];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < BHT_SIZE; i++) begin
        hist_q[i] <= '0;
      end
      for (int i = 0; i < PHT_SIZE; i++) begin
        pht_q[i] <= fetch_pkg::CTR_WEAK_NT;
      end
    end else begin
      hist_q <= hist_d;
      pht_q  <= pht_d;
    end
  end

endmodule

/* src/btb.sv */
// Set-associative branch target buffer
// Ways kept most recent first, lookup per fetch slot, insert on taken retire
// Lookup reads the post-insert contents of the same cycle

`timescale 1ns/1ps

module btb #(
  parameter int BTB_SET_BITS = 3,
  parameter int BTB_WAYS     = 2,
  parameter int TAG_BITS     = 8,
  parameter int FETCH_WIDTH  = 2
) (
  input  logic                               clock,
  input  logic                               reset,
  input  fetch_pkg::addr_t                   lookup_pc,
  output logic [FETCH_WIDTH-1:0]             hit,
  output fetch_pkg::addr_t [FETCH_WIDTH-1:0] hit_target,
  input  logic                               insert,
  input  fetch_pkg::addr_t                   insert_pc,
  input  fetch_pkg::addr_t                   insert_target
);

  localparam int SETS = 1 << BTB_SET_BITS;

  typedef logic [TAG_BITS-1:0]     tag_t;
  typedef logic [BTB_SET_BITS-1:0] set_t;

  logic [BTB_WAYS-1:0] valid_q  [SETS];
  logic [BTB_WAYS-1:0] valid_d  [SETS];
  tag_t                tag_q    [SETS][BTB_WAYS];
  tag_t                tag_d    [SETS][BTB_WAYS];
  fetch_pkg::addr_t    target_q [SETS][BTB_WAYS];
  fetch_pkg::addr_t    target_d [SETS][BTB_WAYS];

  set_t insert_set;
  tag_t insert_tag;
  logic insert_found;
  int   shift_upto;

  assign insert_set = insert_pc[BTB_SET_BITS+1:2];
  assign insert_tag = insert_pc[31 -: TAG_BITS];

  // Insert or refresh at way 0, older ways slide down toward the last way
  always_comb begin
    valid_d      = valid_q;
    tag_d        = tag_q;
    target_d     = target_q;
    insert_found = 1'b0;
    shift_upto   = BTB_WAYS - 1;
    if (insert) begin
      // A hit only pushes down the ways in front of it
      for (int w = 0; w < BTB_WAYS; w++) begin
        if (!insert_found && valid_q[insert_set][w] && tag_q[insert_set][w] == insert_tag) begin
          insert_found = 1'b1;
          shift_upto   = w;
        end
      end
      for (int w = 1; w < BTB_WAYS; w++) begin
        if (w <= shift_upto) begin
          valid_d[insert_set][w]  = valid_q[insert_set][w-1];
          tag_d[insert_set][w]    = tag_q[insert_set][w-1];
          target_d[insert_set][w] = target_q[insert_set][w-1];
        end
      end
      valid_d[insert_set][0]  = 1'b1;
      tag_d[insert_set][0]    = insert_tag;
      target_d[insert_set][0] = insert_target;
    end
  end

  for (genvar s = 0; s < FETCH_WIDTH; s++) begin : g_slot
    fetch_pkg::addr_t slot_addr;
    set_t             slot_set;
    tag_t             slot_tag;
    logic             slot_hit;
    fetch_pkg::addr_t slot_target;

    assign slot_addr = lookup_pc + fetch_pkg::addr_t'(4 * s);
    assign slot_set  = slot_addr[BTB_SET_BITS+1:2];
    assign slot_tag  = slot_addr[31 -: TAG_BITS];

    // Walk from the oldest way so the most recent match wins
    always_comb begin
      slot_hit    = 1'b0;
      slot_target = '0;
      for (int w = BTB_WAYS - 1; w >= 0; w--) begin
        if (valid_d[slot_set][w] && tag_d[slot_set][w] == slot_tag) begin
          slot_hit    = 1'b1;
          slot_target = target_d[slot_set][w];
        end
      end
    end

    assign hit[s]        = slot_hit;
    assign hit_target[s] = slot_target;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < SETS; i++) begin
        valid_q[i] <= '0;
      end
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clock) begin
    tag_q    <= tag_d;
    target_q <= target_d;
  end

endmodule

/* src/predecode.sv */
// Predecode for one fetch group
// Flags conditional branches and jumps among the valid slots

`timescale 1ns/1ps

module predecode #(
  parameter int FETCH_WIDTH = 2
) (
  input  fetch_pkg::instr_t [FETCH_WIDTH-1:0] fetch_instr,
  input  logic [FETCH_WIDTH-1:0]              fetch_instr_valid,
  output logic [FETCH_WIDTH-1:0]              is_branch
);

  for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_slot
    logic [6:0] opcode;
    logic       is_cond;
    logic       is_jump;

    // Major opcode sits in the low 7 bits
    assign opcode = fetch_instr[i][6:0];

    assign is_cond = (opcode == fetch_pkg::OPC_BRANCH);
    assign is_jump = (opcode == fetch_pkg::OPC_JAL) || (opcode == fetch_pkg::OPC_JALR);

    // Empty slots never count as branches
    assign is_branch[i] = fetch_instr_valid[i] & (is_cond | is_jump);
  end

endmodule

/* src/fetch_pkg.sv */
// Shared types for the fetch front end
// Address, instruction and direction counter types, RV32 major opcodes

package fetch_pkg;

  // Byte address of an instruction
  typedef logic [31:0] addr_t;

  // Raw 32-bit instruction word
  typedef logic [31:0] instr_t;

  // 2-bit saturating direction counter, msb set means taken
  typedef logic [1:0] ctr_t;

  // Counter state after reset
  localparam ctr_t CTR_WEAK_NT = 2'b01;

  // Conditional branches
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Direct jump
  localparam logic [6:0] OPC_JAL = 7'b1101111;

  // Register indirect jump
  localparam logic [6:0] OPC_JALR = 7'b1100111;

endpackage
